/* compile.f */
hdl/game_pkg.sv
hdl/button_conditioner.sv
hdl/point_control.sv
hdl/background_scroller.sv
hdl/matrix_scan.sv
hdl/max7219_serial.sv
hdl/game_top.sv
verification/max7219_monitor.sv
verification/tb_game_top.sv

/* hdl/background_scroller.sv */
`timescale 1ns/100ps

module background_scroller #(
	parameter int SPEED_TICKS = 2**22
) (
	input  logic              clock_50,
	input  logic              rst,
	input  logic              start,
	output game_pkg::matrix_t backg
);

	localparam int CNT_W = $clog2(SPEED_TICKS + 1);

	localparam logic IDLE    = 1'b0;
	localparam logic RUNNING = 1'b1;

	logic             state;
	logic [CNT_W-1:0] speed_cnt;
	logic             tick;

	assign tick = (state == RUNNING) && (speed_cnt == CNT_W'(SPEED_TICKS - 1));

	// Frozen until the first start, then runs until reset
	always_ff @(posedge clock_50) begin
		if (rst) begin
			state <= IDLE;
		end else if (start) begin
			state <= RUNNING;
		end
	end

	//##########################################################
	// Speed counter
	//##########################################################
	always_ff @(posedge clock_50) begin
		if (rst) begin
			speed_cnt <= '0;
		end else if (start || tick) begin
			speed_cnt <= '0;
		end else if (state == RUNNING) begin
			speed_cnt <= speed_cnt + 1'b1;
		end
	end

	//##########################################################
	// Obstacle rows
	//##########################################################
	always_ff @(posedge clock_50) begin
		if (rst) begin
			backg <= game_pkg::BACKG_INIT;
		end else if (start) begin
			backg <= game_pkg::BACKG_INIT;
		end else if (tick) begin
			// Bottom row drops out, empty row enters at the top
			backg <= {game_pkg::row_t'(0), backg[game_pkg::ROWS-1:1]};
		end
	end

endmodule

/* hdl/button_conditioner.sv */
`timescale 1ns/100ps

module button_conditioner #(
	parameter int DEBOUNCE_CYCLES = 16
) (
	input  logic clock_50,
	input  logic rst,
	input  logic button_n,
	output logic press
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic             sync_1;
	logic             sync_2;
	logic             stable;
	logic             stable_q;
	logic [CNT_W-1:0] cnt;

	// Two-flop synchronizer, pin inverted to active high
	always_ff @(posedge clock_50) begin
		if (rst) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
		end else begin
			sync_1 <= ~button_n;
			sync_2 <= sync_1;
		end
	end

	// New level accepted after enough equal samples
	always_ff @(posedge clock_50) begin
		if (rst) begin
			cnt    <= '0;
			stable <= 1'b0;
		end else if (sync_2 == stable) begin
			cnt <= '0;
		end else if (cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
			cnt    <= '0;
			stable <= sync_2;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// One pulse on press, nothing on release
	always_ff @(posedge clock_50) begin
		if (rst) begin
			stable_q <= 1'b0;
			press    <= 1'b0;
		end else begin
			stable_q <= stable;
			press    <= stable & ~stable_q;
		end
	end

endmodule

/* hdl/game_pkg.sv */
package game_pkg;

	// Matrix is square, rows and columns share this size
	localparam int ROWS = 8;

	// One matrix row, bit 7 is the leftmost column
	typedef logic [ROWS-1:0] row_t;

	// Index 0 is the bottom row
	typedef row_t [ROWS-1:0] matrix_t;

	typedef struct packed {
		logic start;
		logic up;
		logic down;
		logic left;
		logic right;
	} buttons_t;

	// MAX7219 serial word, shifted out MSB first
	typedef struct packed {
		logic [3:0] unused;
		logic [3:0] addr;
		logic [7:0] data;
	} max_word_t;

	// Player starts in the bottom row
	localparam matrix_t POINT_INIT = 64'h0000_0000_0000_0010;

	// Two obstacle bars on rows 2 and 4
	localparam matrix_t BACKG_INIT = 64'h0000_00E0_00E0_0000;

	// MAX7219 register addresses
	localparam logic [3:0] REG_DIGIT0       = 4'd1;
	localparam logic [3:0] REG_DECODE       = 4'd9;
	localparam logic [3:0] REG_INTENSITY    = 4'd10;
	localparam logic [3:0] REG_SCAN_LIMIT   = 4'd11;
	localparam logic [3:0] REG_SHUTDOWN     = 4'd12;
	localparam logic [3:0] REG_DISPLAY_TEST = 4'd15;

endpackage

/* hdl/game_top.sv */
`timescale 1ns/100ps

module game_top #(
	parameter int         DEBOUNCE_CYCLES = 16,
	parameter int         SPEED_TICKS     = 2**22,
	parameter int         SCLK_HALF       = 4,
	parameter logic [3:0] INTENSITY       = 4'hA
) (
	input  logic               clock_50,
	input  logic               rst,
	input  game_pkg::buttons_t button_n,
	output logic               max7219_din,
	output logic               max7219_ncs,
	output logic               max7219_clk
);

	localparam int NUM_BUTTONS = $bits(game_pkg::buttons_t);

	logic [NUM_BUTTONS-1:0] press_bits;
	game_pkg::buttons_t     press;
	game_pkg::matrix_t      point;
	game_pkg::matrix_t      backg;
	game_pkg::max_word_t    word;
	logic                   word_valid;
	logic                   word_ready;

	//##########################################################
	// Buttons
	//##########################################################
	for (genvar i = 0; i < NUM_BUTTONS; i++) begin : g_button
		button_conditioner #(
			.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
		) button_conditioner_u (
			.clock_50(clock_50),
			.rst     (rst),
			.button_n(button_n[i]),
			.press   (press_bits[i])
		);
	end

	assign press = press_bits;

	//##########################################################
	// Game state
	//##########################################################
	point_control point_control_u0 (
		.clock_50(clock_50),
		.rst     (rst),
		.press   (press),
		.point   (point)
	);

	background_scroller #(
		.SPEED_TICKS(SPEED_TICKS)
	) background_scroller_u0 (
		.clock_50(clock_50),
		.rst     (rst),
		.start   (press.start),
		.backg   (backg)
	);

	//##########################################################
	// LED matrix output
	//##########################################################
	matrix_scan #(
		.INTENSITY(INTENSITY)
	) matrix_scan_u0 (
		.clock_50  (clock_50),
		.rst       (rst),
		.point     (point),
		.backg     (backg),
		.word      (word),
		.word_valid(word_valid),
		.word_ready(word_ready)
	);

	max7219_serial #(
		.SCLK_HALF(SCLK_HALF)
	) max7219_serial_u0 (
		.clock_50   (clock_50),
		.rst        (rst),
		.word       (word),
		.word_valid (word_valid),
		.word_ready (word_ready),
		.max7219_din(max7219_din),
		.max7219_ncs(max7219_ncs),
		.max7219_clk(max7219_clk)
	);

endmodule

/* hdl/matrix_scan.sv */
`timescale 1ns/100ps

module matrix_scan #(
	parameter logic [3:0] INTENSITY = 4'hA
) (
	input  logic                clock_50,
	input  logic                rst,
	input  game_pkg::matrix_t   point,
	input  game_pkg::matrix_t   backg,
	output game_pkg::max_word_t word,
	output logic                word_valid,
	input  logic                word_ready
);

	localparam int         N           = game_pkg::ROWS;
	localparam logic [3:0] FIRST_DIGIT = 4'd5;
	localparam logic [3:0] LAST_STEP   = 4'd12;

	game_pkg::matrix_t   frame;
	game_pkg::max_word_t next_word;
	logic [3:0]          step;
	logic [2:0]          digit;

	assign frame = point | backg;

	// Steps 0 to 4 are the init list, the rest are digits
	assign digit = 3'(step - FIRST_DIGIT);

	always_comb begin
		next_word = '0;
		case (step)
			4'd0: next_word.addr = game_pkg::REG_DISPLAY_TEST;
			4'd1: begin
				next_word.addr = game_pkg::REG_SCAN_LIMIT;
				next_word.data = 8'd7;
			end
			4'd2: next_word.addr = game_pkg::REG_DECODE;
			4'd3: begin
				next_word.addr = game_pkg::REG_INTENSITY;
				next_word.data = {4'h0, INTENSITY};
			end
			4'd4: begin
				next_word.addr = game_pkg::REG_SHUTDOWN;
				next_word.data = 8'd1;
			end
			default: begin
				// Digit c shows column 7-c, top row in the LSB
				next_word.addr = game_pkg::REG_DIGIT0 + {1'b0, digit};
				for (int r = 0; r < N; r++) begin
					next_word.data[N-1-r] = frame[r][N-1-digit];
				end
			end
		endcase
	end

	//##########################################################
	// Word sequencer
	//##########################################################
	always_ff @(posedge clock_50) begin
		if (rst) begin
			step       <= '0;
			word_valid <= 1'b0;
		end else if (!word_valid) begin
			word_valid <= 1'b1;
		end else if (word_ready) begin
			word_valid <= 1'b0;
			step       <= (step == LAST_STEP) ? FIRST_DIGIT : step + 1'b1;
		end
	end

	// Sampled when offered, held until taken
	always_ff @(posedge clock_50) begin
		if (!word_valid) begin
			word <= next_word;
		end
	end

endmodule

/* hdl/max7219_serial.sv */
`timescale 1ns/100ps

module max7219_serial #(
	parameter int SCLK_HALF = 4
) (
	input  logic                clock_50,
	input  logic                rst,
	input  game_pkg::max_word_t word,
	input  logic                word_valid,
	output logic                word_ready,
	output logic                max7219_din,
	output logic                max7219_ncs,
	output logic                max7219_clk
);

	localparam int DIV_W = $clog2(SCLK_HALF + 1);

	localparam logic [1:0] IDLE  = 2'd0;
	localparam logic [1:0] SHIFT = 2'd1;
	localparam logic [1:0] HOLD  = 2'd2;

	logic [1:0]       state;
	logic [15:0]      shreg;
	logic [DIV_W-1:0] div;
	logic [3:0]       bit_cnt;
	logic             half_done;
	logic             drive_bit;

	assign word_ready = (state == IDLE);
	assign half_done  = (div == DIV_W'(SCLK_HALF - 1));

	// New din value on ncs fall and on every clk fall but the last
	assign drive_bit = (state == SHIFT) && half_done &&
		(max7219_ncs || (max7219_clk && bit_cnt != 4'd15));

	// Parked at the end count in idle so the first event follows acceptance
	always_ff @(posedge clock_50) begin
		if (rst) begin
			div <= '0;
		end else if (state == IDLE || half_done) begin
			div <= (state == IDLE) ? DIV_W'(SCLK_HALF - 1) : '0;
		end else begin
			div <= div + 1'b1;
		end
	end

	always_ff @(posedge clock_50) begin
		if (word_valid && word_ready) begin
			shreg <= word;
		end else if (drive_bit) begin
			shreg <= {shreg[14:0], 1'b0};
		end
	end

	//##########################################################
	// Frame FSM
	//##########################################################
	always_ff @(posedge clock_50) begin
		if (rst) begin
			state       <= IDLE;
			bit_cnt     <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
			max7219_din <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (word_valid) begin
						state   <= SHIFT;
						bit_cnt <= '0;
					end
				end
				SHIFT: begin
					if (drive_bit) begin
						max7219_din <= shreg[15];
					end
					if (half_done) begin
						if (max7219_ncs) begin
							max7219_ncs <= 1'b0;
						end else if (!max7219_clk) begin
							max7219_clk <= 1'b1;
						end else begin
							max7219_clk <= 1'b0;
							if (bit_cnt == 4'd15) begin
								state <= HOLD;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
				end
				HOLD: begin
					// ncs already high here, ready follows one cycle later
					if (max7219_ncs) begin
						state <= IDLE;
					end else if (half_done) begin
						max7219_ncs <= 1'b1;
						max7219_din <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* hdl/point_control.sv */
`timescale 1ns/100ps

module point_control (
	input  logic               clock_50,
	input  logic               rst,
	input  game_pkg::buttons_t press,
	output game_pkg::matrix_t  point
);

	localparam int N = game_pkg::ROWS;

	logic at_bottom;

	// Bottom side comparator, any lit cell in row 0 blocks a move down
	assign at_bottom = |point[0];

	always_ff @(posedge clock_50) begin
		if (rst) begin
			point <= game_pkg::POINT_INIT;
		end else if (press.start) begin
			point <= game_pkg::POINT_INIT;
		end else if (press.up) begin
			// Top row wraps to the bottom
			point <= {point[N-2:0], point[N-1]};
		end else if (press.down) begin
			if (!at_bottom) begin
				point <= {point[0], point[N-1:1]};
			end
		end else if (press.left) begin
			for (int r = 0; r < N; r++) begin
				point[r] <= {point[r][N-2:0], point[r][N-1]};
			end
		end else if (press.right) begin
			for (int r = 0; r < N; r++) begin
				point[r] <= {point[r][0], point[r][N-1:1]};
			end
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_game_top -f compile.f \
	&& ./obj_dir/Vtb_game_top > sim.log 2>&1 \
	|| echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^All checks passed$" sim.log && echo "Result: PASS" || { echo "Result: FAIL"; exit 1; }

/* verification/max7219_monitor.sv */
`timescale 1ns/100ps

module max7219_monitor (
	input  logic                clock_50,
	input  logic                rst,
	input  logic                din,
	input  logic                ncs,
	input  logic                sclk,
	output game_pkg::max_word_t last_word,
	output int                  word_count,
	output int                  last_pulses,
	output int                  bad_frames,
	output game_pkg::matrix_t   shadow
);

	logic        sclk_q;
	logic        ncs_q;
	logic [15:0] shreg;
	int          pulses;
	logic [3:0]  addr;
	logic [2:0]  col;

	assign addr = shreg[11:8];

	// Digit register 1 holds column 7, digit register 8 holds column 0
	assign col = 3'(4'd8 - addr);

	always_ff @(posedge clock_50) begin
		if (rst) begin
			sclk_q      <= 1'b0;
			ncs_q       <= 1'b1;
			shreg       <= '0;
			pulses      <= 0;
			last_word   <= '0;
			word_count  <= 0;
			last_pulses <= 0;
			bad_frames  <= 0;
			shadow      <= '0;
		end else begin
			sclk_q <= sclk;
			ncs_q  <= ncs;
			// Pulses between frames also count, so a stray clk shows up as a bad frame
			if (sclk && !sclk_q) begin
				pulses <= pulses + 1;
				if (!ncs) begin
					shreg <= {shreg[14:0], din};
				end
			end
			if (ncs && !ncs_q) begin
				last_word   <= shreg;
				last_pulses <= pulses;
				word_count  <= word_count + 1;
				pulses      <= 0;
				if (pulses != 16) begin
					bad_frames <= bad_frames + 1;
				end
				// Data bit 7-r is row r
				if (addr >= 4'd1 && addr <= 4'd8) begin
					for (int r = 0; r < game_pkg::ROWS; r++) begin
						shadow[r][col] <= shreg[7-r];
					end
				end
			end
		end
	end

endmodule

/* verification/tb_game_top.sv */
`timescale 1ns/100ps

module tb_game_top;

	localparam int         SPEED_TICKS = 400;
	localparam logic [3:0] INTENSITY   = 4'h3;

	// Field order is start, up, down, left, right
	localparam game_pkg::buttons_t BTN_START = 5'b10000;
	localparam game_pkg::buttons_t BTN_UP    = 5'b01000;
	localparam game_pkg::buttons_t BTN_DOWN  = 5'b00100;
	localparam game_pkg::buttons_t BTN_LEFT  = 5'b00010;
	localparam game_pkg::buttons_t BTN_RIGHT = 5'b00001;

	logic                clock_50;
	logic                rst;
	game_pkg::buttons_t  button_n;
	logic                max7219_din;
	logic                max7219_ncs;
	logic                max7219_clk;
	game_pkg::max_word_t last_word;
	int                  word_count;
	int                  last_pulses;
	int                  bad_frames;
	game_pkg::matrix_t   shadow;

	game_pkg::matrix_t   model_point;
	game_pkg::matrix_t   point_start;
	game_pkg::matrix_t   backg_start;
	logic [31:0]         lfsr;
	int                  checks;
	int                  errors;
	int                  tests;
	bit                  timed_out;

	game_top #(
		.DEBOUNCE_CYCLES(4),
		.SPEED_TICKS    (SPEED_TICKS),
		.SCLK_HALF      (2),
		.INTENSITY      (INTENSITY)
	) i_game_top (
		.clock_50   (clock_50),
		.rst        (rst),
		.button_n   (button_n),
		.max7219_din(max7219_din),
		.max7219_ncs(max7219_ncs),
		.max7219_clk(max7219_clk)
	);

	max7219_monitor monitor_u0 (
		.clock_50   (clock_50),
		.rst        (rst),
		.din        (max7219_din),
		.ncs        (max7219_ncs),
		.sclk       (max7219_clk),
		.last_word  (last_word),
		.word_count (word_count),
		.last_pulses(last_pulses),
		.bad_frames (bad_frames),
		.shadow     (shadow)
	);

	initial begin
		clock_50 = 1'b0;
		forever #2 clock_50 = ~clock_50;
	end

	//##########################################################
	// Helpers
	//##########################################################

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr_step(lfsr);
			value = (value << 1) | 32'(lfsr[0]);
		end
	endtask

	// Expected point after one press, wrap rules per direction
	function automatic game_pkg::matrix_t move_point(input game_pkg::matrix_t p,
		input game_pkg::buttons_t b);
		game_pkg::matrix_t n;
		n = p;
		for (int r = 0; r < game_pkg::ROWS; r++) begin
			for (int c = 0; c < game_pkg::ROWS; c++) begin
				if (b.up) begin
					n[(r+1) % game_pkg::ROWS][c] = p[r][c];
				end else if (b.down && p[0] == '0) begin
					n[r][c] = p[(r+1) % game_pkg::ROWS][c];
				end else if (b.left) begin
					n[r][(c+1) % game_pkg::ROWS] = p[r][c];
				end else if (b.right) begin
					n[r][c] = p[r][(c+1) % game_pkg::ROWS];
				end
			end
		end
		return n;
	endfunction

	function automatic logic [7:0] column_bits(input game_pkg::matrix_t m, input int c);
		logic [7:0] v;
		for (int r = 0; r < game_pkg::ROWS; r++) begin
			v[r] = m[r][c];
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (!timed_out) begin
			checks++;
			assert (actual === expected) else begin
				$display("[FAIL] %s expected %h actual %h", name, expected, actual);
				errors++;
			end
		end
	endtask

	task automatic wait_words(input int count, input int limit);
		int base;
		int cycles;
		base   = word_count;
		cycles = 0;
		while (!timed_out && (word_count - base) < count) begin
			if (cycles >= limit) begin
				$display("Timeout: only %0d of %0d display words arrived", word_count - base,
					count);
				timed_out = 1'b1;
			end else begin
				@(posedge clock_50);
				cycles++;
			end
		end
	endtask

	task automatic wait_digit(input logic [3:0] addr, input int limit);
		int  seen;
		int  cycles;
		bit  found;
		seen   = word_count;
		cycles = 0;
		found  = 1'b0;
		while (!timed_out && !found) begin
			if (cycles >= limit) begin
				$display("Timeout: digit register %0d was never written", addr);
				timed_out = 1'b1;
			end else begin
				@(posedge clock_50);
				cycles++;
				if (word_count != seen) begin
					seen  = word_count;
					found = (last_word.addr == addr);
				end
			end
		end
	endtask

	// Button held low for 20 cycles, then released
	task automatic press_button(input game_pkg::buttons_t b);
		button_n <= ~b;
		repeat (20) @(posedge clock_50);
		button_n <= '1;
	endtask

	// Ten words leave a full refresh sampled after the press
	task automatic move_and_check(input game_pkg::buttons_t b, input string name);
		int gap;
		random_bits(4, gap);
		repeat (gap + 10) @(posedge clock_50);
		press_button(b);
		model_point = move_point(model_point, b);
		wait_words(10, 1200);
		check_value({"shadow after ", name}, model_point | backg_start, shadow);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		if (timed_out) begin
			$display("test %0d %s: aborted", tests, name);
		end else begin
			$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
		end
	endtask

	//##########################################################
	// Test sequence
	//##########################################################
	initial begin
		logic [15:0] init_words [5];
		logic [7:0]  col;
		int          errs;
		int          dir;
		int          row;
		rst       = 1'b1;
		button_n  = '1;
		lfsr      = 32'h043b9580;
		checks    = 0;
		errors    = 0;
		tests     = 0;
		timed_out = 1'b0;
		point_start    = '0;
		point_start[0] = 8'h10;
		backg_start    = '0;
		backg_start[2] = 8'hE0;
		backg_start[4] = 8'hE0;
		model_point    = point_start;
		// Address in bits 11:8, data in bits 7:0
		init_words[0] = 16'h0F00;
		init_words[1] = 16'h0B07;
		init_words[2] = 16'h0900;
		init_words[3] = {8'h0A, 4'h0, INTENSITY};
		init_words[4] = 16'h0C01;

		repeat (3) @(posedge clock_50);
		rst <= 1'b0;

		errs = errors;
		check_value("max7219_ncs", 64'h1, 64'(max7219_ncs));
		check_value("max7219_clk", 64'h0, 64'(max7219_clk));
		check_value("max7219_din", 64'h0, 64'(max7219_din));
		for (int i = 0; i < 5; i++) begin
			wait_words(1, 400);
			check_value("init word", 64'(init_words[i]), 64'(last_word));
			check_value("clk pulses per word", 64'd16, 64'(last_pulses));
		end
		finish_test("power-up init list", errs);

		errs = errors;
		wait_words(10, 1200);
		check_value("shadow before start", point_start | backg_start, shadow);
		// About three speed periods without a start
		wait_words(20, 2000);
		check_value("shadow still frozen", point_start | backg_start, shadow);
		finish_test("frozen background", errs);

		errs = errors;
		for (int i = 0; i < 8; i++) begin
			random_bits(2, dir);
			case (dir)
				0:       move_and_check(BTN_LEFT, "left");
				1:       move_and_check(BTN_RIGHT, "right");
				default: move_and_check(BTN_UP, "up");
			endcase
		end
		finish_test("left, right and up moves", errs);

		errs = errors;
		row = 0;
		for (int r = 0; r < game_pkg::ROWS; r++) begin
			if (model_point[r] != '0) begin
				row = r;
			end
		end
		// Wrap the point into the bottom row first
		for (int i = 0; i < (game_pkg::ROWS - row) % game_pkg::ROWS; i++) begin
			move_and_check(BTN_UP, "up");
		end
		move_and_check(BTN_DOWN, "down in bottom row");
		move_and_check(BTN_UP, "up");
		move_and_check(BTN_DOWN, "down");
		finish_test("down moves", errs);

		errs = errors;
		press_button(BTN_START);
		model_point = point_start;
		wait_words(7, 800);
		wait_words(10, 1200);
		// Obstacle columns 7 to 5 are one or two rows lower
		for (int c = 5; c < 8; c++) begin
			col = column_bits(shadow, c);
			if (!timed_out) begin
				checks++;
				assert (col == 8'h0A || col == 8'h05) else begin
					$display("[FAIL] shadow column %0d expected 0a or 05 actual %h", c, col);
					errors++;
				end
			end
		end
		check_value("shadow columns 4 to 0", point_start, shadow & {8{8'h1F}});
		// Start lands while digit 7 is shifted, so digits 1 to 4 sample before the next tick
		wait_digit(4'd6, 800);
		press_button(BTN_START);
		wait_words(10, 1200);
		check_value("shadow after restart", point_start | backg_start, shadow);
		check_value("bad frames", 64'h0, 64'(bad_frames));
		finish_test("start and scrolling", errs);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
